// File: hdl/bus_pkg.sv
package bus_pkg;

  localparam int ADDR_W = 32;
  localparam int XLEN = 32;
  localparam int BUS_W = 64;
  localparam int STRB_W = 8;
  localparam int LANES = BUS_W / XLEN;

  // mtime word addresses
  localparam logic [ADDR_W-1:0] TIMER_LO_ADDR = 32'h0200_BFF8;
  localparam logic [ADDR_W-1:0] TIMER_HI_ADDR = 32'h0200_BFFC;

  localparam logic [1:0] AXI_OKAY = 2'b00;

  // encoding follows the AXI size code
  typedef enum logic [1:0] {
    SZ_BYTE = 2'd0,
    SZ_HALF = 2'd1,
    SZ_WORD = 2'd2
  } acc_size_e;

  // bus word, whole or split into 32-bit lanes
  typedef union packed {
    logic [BUS_W-1:0] full;
    logic [LANES-1:0][XLEN-1:0] lane;
  } bus_word_u;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [XLEN-1:0] wdata;
    acc_size_e size;
    logic write;
  } lsu_req_t;

  typedef struct packed {
    logic [XLEN-1:0] rdata;
    logic err;
  } core_rsp_t;

  // shared by AR and AW
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    acc_size_e size;
  } axi_addr_t;

  typedef struct packed {
    bus_word_u data;
    logic [STRB_W-1:0] strb;
  } axi_w_t;

  typedef struct packed {
    bus_word_u data;
    logic [1:0] resp;
  } axi_r_t;

  typedef struct packed {
    logic [1:0] resp;
  } axi_b_t;

endpackage

// File: hdl/lane_align.sv
`timescale 1ns/10ps

module lane_align (
  input  bus_pkg::lsu_req_t cur_req_i,
  input  bus_pkg::axi_r_t r_i,
  output bus_pkg::axi_addr_t ar_o,
  output bus_pkg::axi_addr_t aw_o,
  output bus_pkg::axi_w_t w_o,
  output logic [bus_pkg::XLEN-1:0] rd_word_o,
  output logic rd_err_o
);
  import bus_pkg::*;

  logic [1:0] byte_off;
  logic [XLEN-1:0] wr_shifted;
  logic [STRB_W-1:0] strb_base;
  logic [XLEN-1:0] rd_lane;
  logic [XLEN-1:0] rd_shifted;

  assign byte_off = cur_req_i.addr[1:0];

  // address channels carry the request as is
  assign ar_o.addr = cur_req_i.addr;
  assign ar_o.size = cur_req_i.size;
  assign aw_o.addr = cur_req_i.addr;
  assign aw_o.size = cur_req_i.size;

  // write data placed at its byte offset
  assign wr_shifted = cur_req_i.wdata << {byte_off, 3'b000};

  // same word on both lanes, strobe picks the bytes
  assign w_o.data.lane[0] = wr_shifted;
  assign w_o.data.lane[1] = wr_shifted;

  always_comb
  begin
    case (cur_req_i.size)
      SZ_BYTE:
        strb_base = 8'b0000_0001;
      SZ_HALF:
        strb_base = 8'b0000_0011;
      default:
        strb_base = 8'b0000_1111;
    endcase
  end

  assign w_o.strb = strb_base << cur_req_i.addr[2:0];

  // read lane by address bit 2
  assign rd_lane = r_i.data.lane[cur_req_i.addr[2]];
  assign rd_shifted = rd_lane >> {byte_off, 3'b000};

  always_comb
  begin
    case (cur_req_i.size)
      SZ_BYTE:
        rd_word_o = {{(XLEN - 8){1'b0}}, rd_shifted[7:0]};
      SZ_HALF:
        rd_word_o = {{(XLEN - 16){1'b0}}, rd_shifted[15:0]};
      default:
        rd_word_o = rd_shifted;
    endcase
  end

  // anything but OKAY is an error
  assign rd_err_o = (r_i.resp != AXI_OKAY);

endmodule

// File: hdl/core_timer.sv
`timescale 1ns/10ps

module core_timer (
  input  logic clk,
  input  logic rst,
  input  logic sel_i,
  input  logic we_i,
  input  logic hi_i,
  input  logic [bus_pkg::XLEN-1:0] wdata_i,
  output logic [bus_pkg::XLEN-1:0] rdata_o
);
  import bus_pkg::*;

  logic [2*XLEN-1:0] mtime_q;
  logic [2*XLEN-1:0] mtime_inc;

  assign mtime_inc = mtime_q + 1'b1;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime_q <= '0;
    end
    else if (sel_i && we_i)
    begin
      // written half replaced, other half keeps counting
      if (hi_i)
        mtime_q <= {wdata_i, mtime_inc[XLEN-1:0]};
      else
        mtime_q <= {mtime_inc[2*XLEN-1:XLEN], wdata_i};
    end
    else
    begin
      mtime_q <= mtime_inc;
    end
  end

  // sample at selection
  always_ff @(posedge clk)
  begin
    if (sel_i)
      rdata_o <= hi_i ? mtime_q[2*XLEN-1:XLEN] : mtime_q[XLEN-1:0];
  end

endmodule

// File: hdl/bus_arbiter.sv
`timescale 1ns/10ps

module bus_arbiter (
  input  logic clk,
  input  logic rst,
  input  bus_pkg::fetch_req_t fetch_req_i,
  input  logic fetch_valid_i,
  output logic fetch_ready_o,
  input  bus_pkg::lsu_req_t lsu_req_i,
  input  logic lsu_valid_i,
  output logic lsu_ready_o,
  output bus_pkg::core_rsp_t fetch_rsp_o,
  output logic fetch_rsp_valid_o,
  output bus_pkg::core_rsp_t lsu_rsp_o,
  output logic lsu_rsp_valid_o,
  output bus_pkg::lsu_req_t cur_req_o,
  output logic ar_valid_o,
  input  logic ar_ready_i,
  output logic aw_valid_o,
  input  logic aw_ready_i,
  output logic w_valid_o,
  input  logic w_ready_i,
  input  logic r_valid_i,
  output logic r_ready_o,
  input  logic [bus_pkg::XLEN-1:0] rd_word_i,
  input  logic rd_err_i,
  input  bus_pkg::axi_b_t b_i,
  input  logic b_valid_i,
  output logic b_ready_o,
  output logic tmr_sel_o,
  output logic tmr_we_o,
  input  logic [bus_pkg::XLEN-1:0] tmr_rdata_i
);
  import bus_pkg::*;

  typedef enum logic [2:0] {IDLE, AR, R, WR, B, TMR, RSP} state_e;

  state_e state_q;
  logic last_fetch_q;
  logic owner_fetch_q;
  logic aw_done_q;
  logic w_done_q;
  logic tmr_rd_q;
  lsu_req_t req_q;
  logic [XLEN-1:0] rsp_rdata_q;
  logic rsp_err_q;

  logic pick_fetch;
  logic pick_lsu;
  logic tmr_hit;
  logic aw_hs;
  logic w_hs;
  lsu_req_t acc_req;
  core_rsp_t rsp;

  // fetch wins ties unless it had the last grant
  assign pick_fetch = fetch_valid_i && (!lsu_valid_i || !last_fetch_q);
  assign pick_lsu = lsu_valid_i && !pick_fetch;
  assign fetch_ready_o = (state_q == IDLE) && pick_fetch;
  assign lsu_ready_o = (state_q == IDLE) && pick_lsu;

  assign tmr_hit = pick_lsu &&
                   ({lsu_req_i.addr[ADDR_W-1:2], 2'b00} == TIMER_LO_ADDR ||
                    {lsu_req_i.addr[ADDR_W-1:2], 2'b00} == TIMER_HI_ADDR);

  always_comb
  begin
    if (pick_fetch)
    begin
      acc_req.addr = fetch_req_i.addr;
      acc_req.wdata = '0;
      acc_req.size = SZ_WORD;
      acc_req.write = 1'b0;
    end
    else
    begin
      acc_req = lsu_req_i;
    end
  end

  assign aw_hs = aw_valid_o && aw_ready_i;
  assign w_hs = w_valid_o && w_ready_i;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= IDLE;
      last_fetch_q <= 1'b0;
      owner_fetch_q <= 1'b0;
      aw_done_q <= 1'b0;
      w_done_q <= 1'b0;
      tmr_rd_q <= 1'b0;
    end
    else
    begin
      case (state_q)
        IDLE:
          if (pick_fetch || pick_lsu)
          begin
            last_fetch_q <= pick_fetch;
            owner_fetch_q <= pick_fetch;
            aw_done_q <= 1'b0;
            w_done_q <= 1'b0;
            tmr_rd_q <= tmr_hit && !lsu_req_i.write;
            if (tmr_hit)
              state_q <= TMR;
            else if (acc_req.write)
              state_q <= WR;
            else
              state_q <= AR;
          end
        AR:
          if (ar_ready_i)
            state_q <= R;
        R:
          if (r_valid_i)
            state_q <= RSP;
        WR:
        begin
          aw_done_q <= aw_done_q || aw_hs;
          w_done_q <= w_done_q || w_hs;
          if ((aw_done_q || aw_hs) && (w_done_q || w_hs))
            state_q <= B;
        end
        B:
          if (b_valid_i)
            state_q <= RSP;
        TMR:
          state_q <= RSP;
        RSP:
          state_q <= IDLE;
        default:
          state_q <= IDLE;
      endcase
    end
  end

  // transaction and response payload
  always_ff @(posedge clk)
  begin
    if (state_q == IDLE && (pick_fetch || pick_lsu))
      req_q <= acc_req;
    if (state_q == R && r_valid_i)
    begin
      rsp_rdata_q <= rd_word_i;
      rsp_err_q <= rd_err_i;
    end
    else if ((state_q == B && b_valid_i) || state_q == TMR)
    begin
      rsp_rdata_q <= '0;
      rsp_err_q <= (state_q == B) && (b_i.resp != AXI_OKAY);
    end
  end

  assign ar_valid_o = (state_q == AR);
  assign r_ready_o = (state_q == R);
  assign aw_valid_o = (state_q == WR) && !aw_done_q;
  assign w_valid_o = (state_q == WR) && !w_done_q;
  assign b_ready_o = (state_q == B);
  assign tmr_sel_o = (state_q == TMR);
  assign tmr_we_o = (state_q == TMR) && req_q.write;
  assign cur_req_o = req_q;

  // timer read data arrives registered in RSP
  assign rsp.rdata = tmr_rd_q ? tmr_rdata_i : rsp_rdata_q;
  assign rsp.err = rsp_err_q;

  assign fetch_rsp_o = rsp;
  assign lsu_rsp_o = rsp;
  assign fetch_rsp_valid_o = (state_q == RSP) && owner_fetch_q;
  assign lsu_rsp_valid_o = (state_q == RSP) && !owner_fetch_q;

endmodule

// File: hdl/bus_subsystem_top.sv
`timescale 1ns/10ps

module bus_subsystem_top (
  input  logic clk,
  input  logic rst,
  input  bus_pkg::fetch_req_t fetch_req_i,
  input  logic fetch_valid_i,
  output logic fetch_ready_o,
  output bus_pkg::core_rsp_t fetch_rsp_o,
  output logic fetch_rsp_valid_o,
  input  bus_pkg::lsu_req_t lsu_req_i,
  input  logic lsu_valid_i,
  output logic lsu_ready_o,
  output bus_pkg::core_rsp_t lsu_rsp_o,
  output logic lsu_rsp_valid_o,
  output bus_pkg::axi_addr_t ar_o,
  output logic ar_valid_o,
  input  logic ar_ready_i,
  output bus_pkg::axi_addr_t aw_o,
  output logic aw_valid_o,
  input  logic aw_ready_i,
  output bus_pkg::axi_w_t w_o,
  output logic w_valid_o,
  input  logic w_ready_i,
  input  bus_pkg::axi_r_t r_i,
  input  logic r_valid_i,
  output logic r_ready_o,
  input  bus_pkg::axi_b_t b_i,
  input  logic b_valid_i,
  output logic b_ready_o
);
  import bus_pkg::*;

  lsu_req_t cur_req;
  logic [XLEN-1:0] rd_word;
  logic rd_err;
  logic tmr_sel;
  logic tmr_we;
  logic [XLEN-1:0] tmr_rdata;

  bus_arbiter bus_arbiter_inst (
    .clk(clk),
    .rst(rst),
    .fetch_req_i(fetch_req_i),
    .fetch_valid_i(fetch_valid_i),
    .fetch_ready_o(fetch_ready_o),
    .lsu_req_i(lsu_req_i),
    .lsu_valid_i(lsu_valid_i),
    .lsu_ready_o(lsu_ready_o),
    .fetch_rsp_o(fetch_rsp_o),
    .fetch_rsp_valid_o(fetch_rsp_valid_o),
    .lsu_rsp_o(lsu_rsp_o),
    .lsu_rsp_valid_o(lsu_rsp_valid_o),
    .cur_req_o(cur_req),
    .ar_valid_o(ar_valid_o),
    .ar_ready_i(ar_ready_i),
    .aw_valid_o(aw_valid_o),
    .aw_ready_i(aw_ready_i),
    .w_valid_o(w_valid_o),
    .w_ready_i(w_ready_i),
    .r_valid_i(r_valid_i),
    .r_ready_o(r_ready_o),
    .rd_word_i(rd_word),
    .rd_err_i(rd_err),
    .b_i(b_i),
    .b_valid_i(b_valid_i),
    .b_ready_o(b_ready_o),
    .tmr_sel_o(tmr_sel),
    .tmr_we_o(tmr_we),
    .tmr_rdata_i(tmr_rdata)
  );

  lane_align lane_align_inst (
    .cur_req_i(cur_req),
    .r_i(r_i),
    .ar_o(ar_o),
    .aw_o(aw_o),
    .w_o(w_o),
    .rd_word_o(rd_word),
    .rd_err_o(rd_err)
  );

  // address bit 2 selects the mtime half
  core_timer core_timer_inst (
    .clk(clk),
    .rst(rst),
    .sel_i(tmr_sel),
    .we_i(tmr_we),
    .hi_i(cur_req.addr[2]),
    .wdata_i(cur_req.wdata),
    .rdata_o(tmr_rdata)
  );

endmodule

// File: verification/axi_mem_model.sv
`timescale 1ns/10ps

module axi_mem_model (
  input  logic clk,
  input  logic rst,
  // stall bits for ar, aw, w, r, b
  input  logic [4:0] stall_i,
  input  bus_pkg::axi_addr_t ar_i,
  input  logic ar_valid_i,
  output logic ar_ready_o,
  input  bus_pkg::axi_addr_t aw_i,
  input  logic aw_valid_i,
  output logic aw_ready_o,
  input  bus_pkg::axi_w_t w_i,
  input  logic w_valid_i,
  output logic w_ready_o,
  output bus_pkg::axi_r_t r_o,
  output logic r_valid_o,
  input  logic r_ready_i,
  output bus_pkg::axi_b_t b_o,
  output logic b_valid_o,
  input  logic b_ready_i
);
  import bus_pkg::*;

  logic [XLEN-1:0] mem [logic [ADDR_W-1:0]];
  logic rd_busy_q;
  logic aw_got_q;
  logic w_got_q;
  axi_addr_t rd_q;
  axi_addr_t wa_q;
  axi_w_t wd_q;
  logic wr_fire;

  // untouched words read back a pattern of their own address
  function automatic logic [XLEN-1:0] word_at(input logic [ADDR_W-1:0] a);
    logic [ADDR_W-1:0] wa;
    wa = {a[ADDR_W-1:2], 2'b00};
    if (mem.exists(wa))
      return mem[wa];
    return {wa[15:0], wa[31:16]} ^ 32'hc3a5_0f96;
  endfunction

  function automatic logic in_err_window(input logic [ADDR_W-1:0] a);
    return a >= 32'hf000_0000;
  endfunction

  task automatic store_beat();
    logic [ADDR_W-1:0] base;
    logic [XLEN-1:0] word;
    int l;
    int b;
    base = {wa_q.addr[ADDR_W-1:3], 3'b000};
    for (l = 0; l < LANES; l++)
    begin
      word = word_at(base + ADDR_W'(4 * l));
      for (b = 0; b < 4; b++)
        if (wd_q.strb[4*l+b])
          word[8*b +: 8] = wd_q.data.lane[l][8*b +: 8];
      mem[base + ADDR_W'(4 * l)] = word;
    end
  endtask

  assign ar_ready_o = !rd_busy_q && !stall_i[0];
  assign aw_ready_o = !aw_got_q && !stall_i[1];
  assign w_ready_o = !w_got_q && !stall_i[2];
  assign wr_fire = aw_got_q && w_got_q && !b_valid_o && !stall_i[4];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rd_busy_q <= 1'b0;
      r_valid_o <= 1'b0;
      aw_got_q <= 1'b0;
      w_got_q <= 1'b0;
      b_valid_o <= 1'b0;
    end
    else
    begin
      if (ar_valid_i && ar_ready_o)
      begin
        rd_busy_q <= 1'b1;
        rd_q <= ar_i;
      end
      if (rd_busy_q && !r_valid_o && !stall_i[3])
      begin
        r_valid_o <= 1'b1;
        r_o.data.lane[0] <= in_err_window(rd_q.addr) ? '0 : word_at({rd_q.addr[31:3], 3'b000});
        r_o.data.lane[1] <= in_err_window(rd_q.addr) ? '0 : word_at({rd_q.addr[31:3], 3'b100});
        r_o.resp <= in_err_window(rd_q.addr) ? 2'd2 : AXI_OKAY;
      end
      if (r_valid_o && r_ready_i)
      begin
        r_valid_o <= 1'b0;
        rd_busy_q <= 1'b0;
      end
      if (aw_valid_i && aw_ready_o)
      begin
        aw_got_q <= 1'b1;
        wa_q <= aw_i;
      end
      if (w_valid_i && w_ready_o)
      begin
        w_got_q <= 1'b1;
        wd_q <= w_i;
      end
      if (wr_fire)
      begin
        b_valid_o <= 1'b1;
        b_o.resp <= in_err_window(wa_q.addr) ? 2'd2 : AXI_OKAY;
      end
      if (b_valid_o && b_ready_i)
      begin
        b_valid_o <= 1'b0;
        aw_got_q <= 1'b0;
        w_got_q <= 1'b0;
      end
    end
  end

  // writes land when the response is raised
  always @(posedge clk)
  begin
    if (!rst && wr_fire && !in_err_window(wa_q.addr))
      store_beat();
  end

endmodule

// File: verification/tb_bus_subsystem.sv
`timescale 1ns/10ps

module tb_bus_subsystem;
  import bus_pkg::*;

  localparam int CLK_HALF = 4;
  localparam int ROW_CYCLES = 200;

  typedef struct packed {
    logic fetch;
    logic write;
    logic pair;
    logic tmr_inc;
    logic [ADDR_W-1:0] addr;
    acc_size_e size;
    logic [XLEN-1:0] wdata;
    core_rsp_t exp;
  } row_t;

  logic clk;
  logic rst;
  fetch_req_t fetch_req;
  logic fetch_valid, fetch_ready, fetch_rsp_valid;
  core_rsp_t fetch_rsp;
  lsu_req_t lsu_req;
  logic lsu_valid, lsu_ready, lsu_rsp_valid;
  core_rsp_t lsu_rsp;
  axi_addr_t ar, aw;
  axi_w_t w;
  axi_r_t r;
  axi_b_t b;
  logic ar_valid, ar_ready, aw_valid, aw_ready, w_valid, w_ready;
  logic r_valid, r_ready, b_valid, b_ready;
  logic [4:0] stall;

  row_t tbl[$];
  logic [7:0] shadow [logic [ADDR_W-1:0]];
  logic [31:0] lfsr;
  logic [XLEN-1:0] tmr_hi_val;
  logic [XLEN-1:0] last_lo;
  logic last_fetch;
  logic table_done;
  int k;

  bus_subsystem_top bus_subsystem_top_inst (
    .clk(clk), .rst(rst),
    .fetch_req_i(fetch_req), .fetch_valid_i(fetch_valid), .fetch_ready_o(fetch_ready),
    .fetch_rsp_o(fetch_rsp), .fetch_rsp_valid_o(fetch_rsp_valid),
    .lsu_req_i(lsu_req), .lsu_valid_i(lsu_valid), .lsu_ready_o(lsu_ready),
    .lsu_rsp_o(lsu_rsp), .lsu_rsp_valid_o(lsu_rsp_valid),
    .ar_o(ar), .ar_valid_o(ar_valid), .ar_ready_i(ar_ready),
    .aw_o(aw), .aw_valid_o(aw_valid), .aw_ready_i(aw_ready),
    .w_o(w), .w_valid_o(w_valid), .w_ready_i(w_ready),
    .r_i(r), .r_valid_i(r_valid), .r_ready_o(r_ready),
    .b_i(b), .b_valid_i(b_valid), .b_ready_o(b_ready)
  );

  axi_mem_model axi_mem_model_inst (
    .clk(clk), .rst(rst), .stall_i(stall),
    .ar_i(ar), .ar_valid_i(ar_valid), .ar_ready_o(ar_ready),
    .aw_i(aw), .aw_valid_i(aw_valid), .aw_ready_o(aw_ready),
    .w_i(w), .w_valid_i(w_valid), .w_ready_o(w_ready),
    .r_o(r), .r_valid_o(r_valid), .r_ready_i(r_ready),
    .b_o(b), .b_valid_o(b_valid), .b_ready_i(b_ready)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #CLK_HALF clk = ~clk;
  end

  function automatic logic lfsr_bit();
    logic out;
    out = lfsr[0];
    lfsr = (lfsr >> 1) ^ (out ? 32'h8020_0003 : 32'h0);
    return out;
  endfunction

  function automatic logic [31:0] lfsr_word();
    logic [31:0] v;
    int i;
    for (i = 0; i < 32; i++)
      v[i] = lfsr_bit();
    return v;
  endfunction

  function automatic int size_bytes(input acc_size_e s);
    return (s == SZ_BYTE) ? 1 : (s == SZ_HALF) ? 2 : 4;
  endfunction

  function automatic logic is_timer(input logic [ADDR_W-1:0] a);
    return {a[ADDR_W-1:2], 2'b00} == TIMER_LO_ADDR || {a[ADDR_W-1:2], 2'b00} == TIMER_HI_ADDR;
  endfunction

  // preload pattern of the slave memory
  function automatic logic [7:0] shadow_byte(input logic [ADDR_W-1:0] a);
    logic [ADDR_W-1:0] wa;
    logic [XLEN-1:0] word;
    wa = {a[ADDR_W-1:2], 2'b00};
    word = {wa[15:0], wa[31:16]} ^ 32'hc3a5_0f96;
    if (shadow.exists(a))
      return shadow[a];
    return word[8*a[1:0] +: 8];
  endfunction

  // store bytes at their place in the 64-bit bus word
  function automatic axi_w_t w_expect(input row_t row);
    axi_w_t e;
    int i;
    e.data.full = '0;
    e.strb = '0;
    for (i = 0; i < size_bytes(row.size); i++)
    begin
      e.data.full[8*(row.addr[2:0] + i) +: 8] = row.wdata[8*i +: 8];
      e.strb[row.addr[2:0] + i] = 1'b1;
    end
    return e;
  endfunction

  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_rsp(input string name, input core_rsp_t got, input core_rsp_t exp);
    if (got !== exp)
      stop_with_error($sformatf(
        "** Error at %0t ns: %s expected rdata %h err %b, got rdata %h err %b",
        $time, name, exp.rdata, exp.err, got.rdata, got.err));
  endtask

  task automatic check_addr(input string name, input axi_addr_t got, input axi_addr_t exp);
    if (got !== exp)
      stop_with_error($sformatf(
        "** Error at %0t ns: %s expected addr %h size %0d, got addr %h size %0d",
        $time, name, exp.addr, exp.size, got.addr, got.size));
  endtask

  // only bytes under the strobe carry data
  task automatic check_w(input string name, input axi_w_t got, input axi_w_t exp);
    logic [BUS_W-1:0] mask;
    int i;
    for (i = 0; i < STRB_W; i++)
      mask[8*i +: 8] = {8{exp.strb[i]}};
    if (got.strb !== exp.strb || ((got.data.full ^ exp.data.full) & mask) !== '0)
      stop_with_error($sformatf(
        "** Error at %0t ns: %s expected data %h strb %b, got data %h strb %b",
        $time, name, exp.data.full, exp.strb, got.data.full, got.strb));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_with_error($sformatf("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, got));
  endtask

  task automatic check_quiet(input string when);
    if ({fetch_ready, lsu_ready, fetch_rsp_valid, lsu_rsp_valid, ar_valid, aw_valid, w_valid,
         r_ready, b_ready} !== '0)
      stop_with_error($sformatf("a valid or ready output is not low %s, at %0t ns",
                                when, $time));
  endtask

  // expected values follow the shadow memory as rows are added
  task automatic add_row(input logic fetch, input logic write, input logic [ADDR_W-1:0] addr,
                         input acc_size_e size, input logic pair);
    row_t row;
    int i;
    row.fetch = fetch;
    row.write = write;
    row.pair = pair;
    row.addr = addr;
    row.size = fetch ? SZ_WORD : size;
    row.wdata = write ? lfsr_word() : '0;
    row.tmr_inc = 1'b0;
    row.exp = '0;
    row.exp.err = !is_timer(addr) && (addr >= 32'hf000_0000);
    if (is_timer(addr))
    begin
      if (write && addr[2])
        tmr_hi_val = row.wdata;
      else if (!write && addr[2])
        row.exp.rdata = tmr_hi_val;
      else if (!write)
        row.tmr_inc = 1'b1;
    end
    else if (!row.exp.err)
    begin
      for (i = 0; i < size_bytes(row.size); i++)
        if (write)
          shadow[addr + ADDR_W'(i)] = row.wdata[8*i +: 8];
        else
          row.exp.rdata[8*i +: 8] = shadow_byte(addr + ADDR_W'(i));
    end
    tbl.push_back(row);
  endtask

  task automatic build_table();
    int base;
    int s;
    int off;
    int ls;
    int lo;
    int n;
    add_row(1'b1, 1'b0, 32'h0000_1000, SZ_WORD, 1'b0);
    add_row(1'b1, 1'b0, 32'h0000_1004, SZ_WORD, 1'b0);
    // every store size and offset followed by every load
    for (base = 32'h2000; base <= 32'h2004; base += 4)
      for (s = 0; s < 3; s++)
        for (off = 0; off + size_bytes(acc_size_e'(s)) <= 4; off++)
        begin
          add_row(1'b0, 1'b1, ADDR_W'(base + off), acc_size_e'(s), 1'b0);
          for (ls = 0; ls < 3; ls++)
            for (lo = 0; lo + size_bytes(acc_size_e'(ls)) <= 4; lo++)
              add_row(1'b0, 1'b0, ADDR_W'(base + lo), acc_size_e'(ls), 1'b0);
        end
    // both ports at once with and without a fetch just before
    for (n = 0; n < 4; n++)
    begin
      add_row(1'b1, 1'b0, 32'h0000_1000 + ADDR_W'(8 * n), SZ_WORD, 1'b1);
      add_row(1'b0, n[0], 32'h0000_3000 + ADDR_W'(4 * n), SZ_WORD, 1'b0);
      add_row(1'b1, 1'b0, 32'h0000_1100 + ADDR_W'(4 * n), SZ_WORD, 1'b0);
      add_row(1'b1, 1'b0, 32'h0000_1200 + ADDR_W'(4 * n), SZ_WORD, 1'b1);
      add_row(1'b0, 1'b0, 32'h0000_2000 + ADDR_W'(n), SZ_BYTE, 1'b0);
    end
    add_row(1'b0, 1'b1, TIMER_HI_ADDR, SZ_WORD, 1'b0);
    add_row(1'b0, 1'b0, TIMER_HI_ADDR, SZ_WORD, 1'b0);
    add_row(1'b0, 1'b0, TIMER_LO_ADDR, SZ_WORD, 1'b0);
    add_row(1'b0, 1'b0, TIMER_LO_ADDR, SZ_WORD, 1'b0);
    // error window and a normal load after it
    add_row(1'b0, 1'b0, 32'hf000_0012, SZ_HALF, 1'b0);
    add_row(1'b1, 1'b0, 32'hf000_0020, SZ_WORD, 1'b0);
    add_row(1'b0, 1'b1, 32'hf000_0031, SZ_BYTE, 1'b0);
    add_row(1'b0, 1'b0, 32'h0000_2004, SZ_WORD, 1'b0);
  endtask

  task automatic set_stalls();
    int i;
    for (i = 0; i < 5; i++)
      stall[i] = lfsr_bit() & lfsr_bit();
  endtask

  task automatic run_group(input int first, input int count);
    int f_row;
    int l_row;
    int cur;
    int cyc;
    int acc_cyc;
    int left;
    int i;
    logic free;
    logic acc_f;
    logic acc_l;
    logic exp_f;
    axi_addr_t exp_a;
    f_row = -1;
    l_row = -1;
    cur = -1;
    cyc = 0;
    acc_cyc = 0;
    left = count;
    free = 1'b1;
    @(negedge clk);
    for (i = first; i < first + count; i++)
      if (tbl[i].fetch)
        f_row = i;
      else
        l_row = i;
    fetch_valid = (f_row >= 0);
    lsu_valid = (l_row >= 0);
    if (f_row >= 0)
      fetch_req.addr = tbl[f_row].addr;
    if (l_row >= 0)
    begin
      lsu_req.addr = tbl[l_row].addr;
      lsu_req.wdata = tbl[l_row].wdata;
      lsu_req.size = tbl[l_row].size;
      lsu_req.write = tbl[l_row].write;
    end
    while (left > 0)
    begin
      set_stalls();
      #1;
      acc_f = fetch_valid && fetch_ready;
      acc_l = lsu_valid && lsu_ready;
      if (free && (fetch_valid || lsu_valid) && !(fetch_ready || lsu_ready))
        stop_with_error($sformatf("request not accepted by an idle arbiter at %0t ns", $time));
      if (fetch_ready || lsu_ready)
      begin
        // a tie goes to fetch unless fetch had the previous grant
        if (fetch_valid && lsu_valid)
          exp_f = !last_fetch;
        else
          exp_f = fetch_valid;
        check_flag("fetch_ready_o", fetch_ready, exp_f);
        check_flag("lsu_ready_o", lsu_ready, lsu_valid && !exp_f);
        cur = fetch_ready ? f_row : l_row;
        last_fetch = fetch_ready;
        acc_cyc = cyc;
        free = 1'b0;
      end
      if (cur >= 0)
      begin
        exp_a.addr = tbl[cur].addr;
        exp_a.size = tbl[cur].size;
        if (is_timer(tbl[cur].addr) && (ar_valid || aw_valid || w_valid))
          stop_with_error($sformatf("AXI valid raised during a timer access at %0t ns", $time));
        if (ar_valid && ar_ready)
          check_addr("ar_o", ar, exp_a);
        if (aw_valid && aw_ready)
          check_addr("aw_o", aw, exp_a);
        if (w_valid && w_ready)
          check_w("w_o", w, w_expect(tbl[cur]));
      end
      if (fetch_rsp_valid)
      begin
        if (f_row < 0 || f_row != cur)
          stop_with_error($sformatf("fetch response without an open fetch at %0t ns", $time));
        check_rsp("fetch_rsp_o", fetch_rsp, tbl[f_row].exp);
        f_row = -1;
        cur = -1;
        free = 1'b1;
        left--;
      end
      if (lsu_rsp_valid)
      begin
        if (l_row < 0 || l_row != cur)
          stop_with_error($sformatf("load/store response without an open request at %0t ns", $time));
        if (is_timer(tbl[l_row].addr) && cyc - acc_cyc != 2)
          stop_with_error($sformatf(
            "** Error at %0t ns: lsu_rsp_valid_o expected 2 cycles, got %0d",
            $time, cyc - acc_cyc));
        if (tbl[l_row].tmr_inc)
        begin
          if (lsu_rsp.err !== 1'b0 || lsu_rsp.rdata <= last_lo)
            stop_with_error($sformatf(
              "** Error at %0t ns: lsu_rsp_o expected mtime above %h, got %h",
              $time, last_lo, lsu_rsp.rdata));
          last_lo = lsu_rsp.rdata;
        end
        else
          check_rsp("lsu_rsp_o", lsu_rsp, tbl[l_row].exp);
        l_row = -1;
        cur = -1;
        free = 1'b1;
        left--;
      end
      if (left > 0)
      begin
        @(negedge clk);
        cyc++;
        if (acc_f)
          fetch_valid = 1'b0;
        if (acc_l)
          lsu_valid = 1'b0;
      end
    end
  endtask

  initial
  begin
    rst = 1'b1;
    fetch_req = '0;
    fetch_valid = 1'b0;
    lsu_req = '0;
    lsu_valid = 1'b0;
    stall = '0;
    lfsr = 32'hee99;
    tmr_hi_val = '0;
    last_lo = '0;
    last_fetch = 1'b0;
    table_done = 1'b0;
    build_table();
    table_done = 1'b1;
    @(posedge clk);
    @(negedge clk);
    #1;
    check_quiet("during reset");
    @(negedge clk);
    rst = 1'b0;
    #1;
    check_quiet("right after reset");
    @(negedge clk);
    #1;
    check_quiet("in the first idle cycle");
    k = 0;
    while (k < tbl.size())
    begin
      run_group(k, tbl[k].pair ? 2 : 1);
      k += tbl[k].pair ? 2 : 1;
    end
    $display("Test OK");
    $finish;
  end

  initial
  begin
    wait (table_done);
    #((tbl.size() + 4) * ROW_CYCLES * 2 * CLK_HALF);
    stop_with_error("timeout: the table did not finish in time");
  end

endmodule

// File: list.f
hdl/bus_pkg.sv
hdl/lane_align.sv
hdl/core_timer.sv
hdl/bus_arbiter.sv
hdl/bus_subsystem_top.sv
verification/axi_mem_model.sv
verification/tb_bus_subsystem.sv

// File: Makefile
TOP = tb_bus_subsystem

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): list.f hdl/*.sv verification/*.sv
	verilator --binary --timing -f list.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q '^Test OK$$'

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir
